// ==== logic/config_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module config_buffer
   import led_pkg::*;
#(
   parameter int NUM_GROUPS = 8
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       store_config, // One-cycle write strobe
   input  logic [CFG_ADDR_BITS-1:0]   config_addr,
   input  logic [CFG_WORD_BITS-1:0]   config_data,
   output dc_word_u [NUM_GROUPS*DRIVERS_PER_GROUP*LEDS_PER_DRIVER*2-1:0] dc_words,
   output logic [23:0]                bc,           // Brightness control, 3 x 8 bits
   output logic [6:0]                 fc            // Function control
);

   // Two words per LED, then BC low, BC high, FC
   localparam int NUM_DC     = NUM_GROUPS * DRIVERS_PER_GROUP * LEDS_PER_DRIVER * 2;
   localparam int BC_LO_ADDR = NUM_DC;
   localparam int BC_HI_ADDR = NUM_DC + 1;
   localparam int FC_ADDR    = NUM_DC + 2;

   dc_word_u wr_word; // Incoming word with its unused bits cleared

   always_comb
   begin
      wr_word = config_data;
      if (config_addr[0])
         wr_word.b.pad = '0;  // Odd address carries blue only
      else
         wr_word.rg.pad = '0; // Even address carries green and red
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dc_words <= '0;
         bc       <= '0;
         fc       <= '0;
      end
      else if (store_config)
      begin
         if (32'(config_addr) < NUM_DC)
            dc_words[config_addr] <= wr_word;
         else if (config_addr == CFG_ADDR_BITS'(BC_LO_ADDR))
            bc[CFG_WORD_BITS-1:0] <= config_data;
         else if (config_addr == CFG_ADDR_BITS'(BC_HI_ADDR))
            bc[23:CFG_WORD_BITS] <= config_data[7:0]; // Only the top BC byte is kept
         else if (config_addr == CFG_ADDR_BITS'(FC_ADDR))
            fc <= config_data[6:0];
      end
   end

endmodule

`default_nettype wire

// ==== logic/frame_ctrl_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_ctrl_fsm
   import led_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        pixel_shift_start,  // One-cycle start strobes
   input  logic        config_shift_start,
   input  logic        last_bit,           // From the bit counter
   output ctrl_state_t state,
   output logic        load_gs,            // Load grayscale frame this cycle
   output logic        load_cfg,           // Load configuration frame this cycle
   output logic        ready,
   output logic        gslat,
   output logic        xblink,
   output logic        config_has_started
);

   ctrl_state_t next_state;

   // Starts only count in idle, config wins a tie
   assign load_cfg = (state == IDLE) && config_shift_start;
   assign load_gs  = (state == IDLE) && pixel_shift_start && !config_shift_start;

   assign ready = (state != SHIFTING); // Low for exactly the 576 shift cycles

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:
         begin
            if (load_cfg || load_gs)
               next_state = SHIFTING;
         end
         SHIFTING:
         begin
            if (last_bit)
               next_state = GSLAT0;
         end
         GSLAT0:  next_state = GSLAT1;
         GSLAT1:  next_state = GSLAT2;
         GSLAT2:  next_state = XBLINK;
         XBLINK:  next_state = IDLE;
         default: next_state = IDLE;
      endcase
   end

   // Strobes follow the next state so each lines up with its state cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state              <= IDLE;
         gslat              <= 1'b0;
         xblink             <= 1'b0; // Drivers blanked until the first edge
         config_has_started <= 1'b0;
      end
      else
      begin
         state              <= next_state;
         config_has_started <= load_cfg;                // Single cycle after acceptance
         xblink             <= (next_state != XBLINK); // Blank one cycle after the pulse

         case (next_state)
            // gslat marks the frame type: high for config, low for grayscale
            SHIFTING: gslat <= (state == IDLE) ? load_cfg : gslat;
            GSLAT1:   gslat <= 1'b1; // The latch pulse itself
            default:  gslat <= 1'b0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/frame_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_shifter
   import led_pkg::*;
#(
   parameter int NUM_GROUPS = 8
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  ctrl_state_t                state,
   input  logic                       load_gs,
   input  logic                       load_cfg,
   input  logic [NUM_GROUPS*DRIVERS_PER_GROUP*LEDS_PER_DRIVER-1:0][COMP_BITS-1:0] pix_r,
   input  logic [NUM_GROUPS*DRIVERS_PER_GROUP*LEDS_PER_DRIVER-1:0][COMP_BITS-1:0] pix_g,
   input  logic [NUM_GROUPS*DRIVERS_PER_GROUP*LEDS_PER_DRIVER-1:0][COMP_BITS-1:0] pix_b,
   input  dc_word_u [NUM_GROUPS*DRIVERS_PER_GROUP*LEDS_PER_DRIVER*2-1:0] dc_words,
   input  logic [23:0]                bc,
   input  logic [6:0]                 fc,
   output logic [NUM_GROUPS-1:0]      gssin  // One serial lane per group
);

   localparam int PIX_PER_GROUP = DRIVERS_PER_GROUP * LEDS_PER_DRIVER; // 16
   localparam int SLOT_BITS     = GS_PAD_BITS + COMP_BITS;             // 12-bit GS slot
   localparam int LED_GS_BITS   = 3 * SLOT_BITS;                       // B, G, R
   localparam int DC_LED_BITS   = 3 * DC_BITS;                         // 21 per LED
   localparam int DC_FIELD_BITS = LEDS_PER_DRIVER * DC_LED_BITS;       // 168 per driver
   localparam int HDR_BITS      = CFG_PAD_BITS + $bits(fc) + $bits(bc); // Above the DC field

   logic [NUM_GROUPS-1:0][FRAME_BITS-1:0] gs_frame;  // Grayscale image per lane
   logic [NUM_GROUPS-1:0][FRAME_BITS-1:0] cfg_frame; // Configuration image per lane
   logic [NUM_GROUPS-1:0][FRAME_BITS-1:0] shift_q;   // The lane shift registers

   // Grayscale: pixel 15 ends up at the MSB, pixel 0 at the LSB
   always_comb
   begin
      for (int g = 0; g < NUM_GROUPS; g++)
      begin
         for (int p = 0; p < PIX_PER_GROUP; p++)
         begin
            gs_frame[g][LED_GS_BITS*p +: LED_GS_BITS] = {
               GS_PAD_BITS'(0), pix_b[PIX_PER_GROUP*g + p],
               GS_PAD_BITS'(0), pix_g[PIX_PER_GROUP*g + p],
               GS_PAD_BITS'(0), pix_r[PIX_PER_GROUP*g + p]
            };
         end
      end
   end

   // Configuration: per driver pad, FC, BC, then DC for LED 7 down to 0
   always_comb
   begin
      for (int g = 0; g < NUM_GROUPS; g++)
      begin
         for (int d = 0; d < DRIVERS_PER_GROUP; d++)
         begin
            cfg_frame[g][GS_BITS_PER_DRIVER*d + DC_FIELD_BITS +: HDR_BITS] =
               {CFG_PAD_BITS'(0), fc, bc}; // BC and FC are shared by every driver
            for (int l = 0; l < LEDS_PER_DRIVER; l++)
            begin
               // Word pair 2l / 2l+1 of this driver, blue word on the odd address
               cfg_frame[g][GS_BITS_PER_DRIVER*d + DC_LED_BITS*l +: DC_LED_BITS] = {
                  dc_words[2*PIX_PER_GROUP*g + 2*LEDS_PER_DRIVER*d + 2*l + 1].b.blue,
                  dc_words[2*PIX_PER_GROUP*g + 2*LEDS_PER_DRIVER*d + 2*l].rg.green,
                  dc_words[2*PIX_PER_GROUP*g + 2*LEDS_PER_DRIVER*d + 2*l].rg.red
               };
            end
         end
      end
   end

   // Load on the accepted start, then shift left once per shifting cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         shift_q <= '0;
      else if (load_cfg)
         shift_q <= cfg_frame; // Config wins, the FSM never raises both anyway
      else if (load_gs)
         shift_q <= gs_frame;
      else if (state == SHIFTING)
      begin
         for (int g = 0; g < NUM_GROUPS; g++)
            shift_q[g] <= {shift_q[g][FRAME_BITS-2:0], 1'b0};
      end
   end

   // MSB of each lane drives the pin
   always_comb
   begin
      for (int g = 0; g < NUM_GROUPS; g++)
         gssin[g] = shift_q[g][FRAME_BITS-1];
   end

endmodule

`default_nettype wire

// ==== logic/led_pkg.sv ====
`default_nettype none

package led_pkg;

   // Driver geometry
   localparam int LEDS_PER_DRIVER    = 8;   // RGB LEDs on one TLC5951
   localparam int DRIVERS_PER_GROUP  = 2;   // Drivers chained on one serial lane
   localparam int GS_BITS_PER_DRIVER = 288; // Shift register length of one driver
   localparam int FRAME_BITS         = DRIVERS_PER_GROUP * GS_BITS_PER_DRIVER; // 576 per lane

   // Grayscale slot layout, 12 bits per colour
   localparam int COMP_BITS   = 8; // Stored pixel component
   localparam int GS_PAD_BITS = 4; // Zeros above the component

   // Configuration layout
   localparam int CFG_WORD_BITS = 16; // Incoming config word
   localparam int CFG_PAD_BITS  = 89; // Unused top bits of a driver's config frame
   localparam int DC_BITS       = 7;  // One dot-correction field

   // Address and counter widths
   localparam int PIX_ADDR_BITS = 9;  // Pixel number plus 2-bit colour sub-address
   localparam int CFG_ADDR_BITS = 9;
   localparam int CNT_BITS      = 10; // Enough for 0..575

   // Control states
   typedef enum logic [2:0] {
      IDLE,
      SHIFTING,
      GSLAT0,
      GSLAT1,
      GSLAT2,
      XBLINK
   } ctrl_state_t;

   // Dot-correction word, read two ways depending on address parity
   typedef union packed {
      struct packed {
         logic [CFG_WORD_BITS-2*DC_BITS-1:0] pad;   // 2 unused bits
         logic [DC_BITS-1:0]                 green;
         logic [DC_BITS-1:0]                 red;
      } rg;                                        // Even address
      struct packed {
         logic [CFG_WORD_BITS-DC_BITS-1:0]   pad;   // 9 unused bits
         logic [DC_BITS-1:0]                 blue;
      } b;                                         // Odd address
   } dc_word_u;

endpackage

`default_nettype wire

// ==== logic/led_shift_register.sv ====
`timescale 1ns/10ps
`default_nettype none

module led_shift_register
   import led_pkg::*;
#(
   parameter int NUM_GROUPS = 8
)
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [PIX_ADDR_BITS-1:0]  pixel_addr,         // Pixel number and colour
   input  logic [COMP_BITS-1:0]      pixel_data,
   input  logic                      store_pixel,
   input  logic [CFG_WORD_BITS-1:0]  config_data,
   input  logic [CFG_ADDR_BITS-1:0]  config_addr,
   input  logic                      store_config,
   input  logic                      pixel_shift_start,
   input  logic                      config_shift_start, // Priority over pixel start
   output logic                      config_has_started,
   output logic                      ready,              // Low while shifting
   output logic                      gssck,
   output logic [NUM_GROUPS-1:0]     gssin,
   output logic                      gslat,
   output logic                      xblink
);

   localparam int NUM_PIX = NUM_GROUPS * DRIVERS_PER_GROUP * LEDS_PER_DRIVER;

   logic [NUM_PIX-1:0][COMP_BITS-1:0] pix_r;
   logic [NUM_PIX-1:0][COMP_BITS-1:0] pix_g;
   logic [NUM_PIX-1:0][COMP_BITS-1:0] pix_b;
   dc_word_u [2*NUM_PIX-1:0]           dc_words;
   logic [23:0]                        bc;
   logic [6:0]                         fc;
   ctrl_state_t                        state;
   logic                               load_gs;
   logic                               load_cfg;
   logic                               last_bit;

   pixel_buffer #(.NUM_GROUPS(NUM_GROUPS)) u_pixel_buffer (
      .clk, .rst_n, .store_pixel, .pixel_addr, .pixel_data, .pix_r, .pix_g, .pix_b
   );

   config_buffer #(.NUM_GROUPS(NUM_GROUPS)) u_config_buffer (
      .clk, .rst_n, .store_config, .config_addr, .config_data, .dc_words, .bc, .fc
   );

   frame_ctrl_fsm u_frame_ctrl_fsm (
      .clk, .rst_n, .pixel_shift_start, .config_shift_start, .last_bit,
      .state, .load_gs, .load_cfg, .ready, .gslat, .xblink, .config_has_started
   );

   shift_bit_counter u_shift_bit_counter (
      .clk, .rst_n, .state, .last_bit
   );

   frame_shifter #(.NUM_GROUPS(NUM_GROUPS)) u_frame_shifter (
      .clk, .rst_n, .state, .load_gs, .load_cfg,
      .pix_r, .pix_g, .pix_b, .dc_words, .bc, .fc, .gssin
   );

   // Data changes on the rising clk edge, so the drivers sample on the rising gssck edge
   assign gssck = (state == SHIFTING) ? ~clk : 1'b0;

endmodule

`default_nettype wire

// ==== logic/pixel_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixel_buffer
   import led_pkg::*;
#(
   parameter int NUM_GROUPS = 8
)
(
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  store_pixel, // One-cycle write strobe
   input  logic [PIX_ADDR_BITS-1:0]              pixel_addr,  // [8:2] pixel, [1:0] colour
   input  logic [COMP_BITS-1:0]                  pixel_data,
   output logic [NUM_GROUPS*DRIVERS_PER_GROUP*LEDS_PER_DRIVER-1:0][COMP_BITS-1:0] pix_r,
   output logic [NUM_GROUPS*DRIVERS_PER_GROUP*LEDS_PER_DRIVER-1:0][COMP_BITS-1:0] pix_g,
   output logic [NUM_GROUPS*DRIVERS_PER_GROUP*LEDS_PER_DRIVER-1:0][COMP_BITS-1:0] pix_b
);

   localparam int NUM_PIX = NUM_GROUPS * DRIVERS_PER_GROUP * LEDS_PER_DRIVER;

   logic [PIX_ADDR_BITS-3:0] pix_idx; // Pixel number
   logic [1:0]               sub_addr; // Colour select
   logic                     idx_ok;   // Pixel exists for this group count

   assign pix_idx  = pixel_addr[PIX_ADDR_BITS-1:2];
   assign sub_addr = pixel_addr[1:0];
   assign idx_ok   = 32'(pix_idx) < NUM_PIX;

   // The component arrays are the outputs, read combinationally by the shifter
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pix_r <= '0; // Black after reset
         pix_g <= '0;
         pix_b <= '0;
      end
      else if (store_pixel && idx_ok)
      begin
         case (sub_addr)
            2'd0: pix_r[pix_idx] <= pixel_data;
            2'd1: pix_g[pix_idx] <= pixel_data;
            2'd2: pix_b[pix_idx] <= pixel_data;
            default: ; // Sub-address 3 has no colour
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/shift_bit_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module shift_bit_counter
   import led_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  ctrl_state_t state,
   output logic        last_bit  // High on the final bit of a frame
);

   logic [CNT_BITS-1:0] bit_cnt; // Bits already shifted in this frame

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         bit_cnt <= '0;
      else if (state != SHIFTING)
         bit_cnt <= '0;             // Ready for the next frame
      else
         bit_cnt <= bit_cnt + 1'b1; // One bit per shifting cycle
   end

   // Count 575 is the 576th shifting cycle
   assign last_bit = (state == SHIFTING) && (bit_cnt == CNT_BITS'(FRAME_BITS - 1));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the led_shift_register testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   --top-module tb_led_shift_register \
   -f sim.f -o sim_top

./obj_dir/sim_top | tee sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0

// ==== sim.f ====
logic/led_pkg.sv
logic/pixel_buffer.sv
logic/config_buffer.sv
logic/shift_bit_counter.sv
logic/frame_ctrl_fsm.sv
logic/frame_shifter.sv
logic/led_shift_register.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/led_shift_register_properties.sv
verification/tb_led_shift_register.sv

// ==== verification/led_shift_register_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module led_shift_register_properties
(
   input logic clk,
   input logic rst_n,
   input logic pixel_shift_start,
   input logic config_shift_start,
   input logic ready,
   input logic gslat,
   input logic xblink,
   input logic config_has_started
);

   // ready only drops after a start strobe seen while ready was high
   a_ready_fall: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(ready) |-> $past(ready && (pixel_shift_start || config_shift_start)))
      else $error("ready fell without a start in idle");

   a_cfg_started_one: assert property (@(posedge clk) disable iff (!rst_n)
      config_has_started |=> !config_has_started)
      else $error("config_has_started lasted more than one cycle");

   // Blank cycle follows the 1 then 0 end of the latch pulse
   a_xblink_after_lat: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(xblink) |-> ($past(gslat, 2) && !$past(gslat)))
      else $error("xblink went low without a preceding gslat pulse");

   a_xblink_one: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(xblink) |=> xblink)
      else $error("xblink stayed low for more than one cycle");

endmodule

`default_nettype wire

// ==== verification/tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_checker
   import led_pkg::*;
#(
   parameter int NUM_GROUPS = 8
)
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [PIX_ADDR_BITS-1:0] pixel_addr,
   input  logic [COMP_BITS-1:0]     pixel_data,
   input  logic                     store_pixel,
   input  logic [CFG_WORD_BITS-1:0] config_data,
   input  logic [CFG_ADDR_BITS-1:0] config_addr,
   input  logic                     store_config,
   input  logic                     pixel_shift_start,
   input  logic                     config_shift_start,
   input  logic                     config_has_started,
   input  logic                     ready,
   input  logic                     gssck,
   input  logic [NUM_GROUPS-1:0]    gssin,
   input  logic                     gslat,
   input  logic                     xblink,
   output int                       errors
);

   localparam int NUM_PIX = NUM_GROUPS * DRIVERS_PER_GROUP * LEDS_PER_DRIVER;
   localparam int NUM_DC  = 2 * NUM_PIX;
   localparam int LAST_PHASE = FRAME_BITS + 4; // Shift cycles, 3 latch cycles, blank cycle

   logic [COMP_BITS-1:0]  m_r [NUM_PIX];    // Reference buffers
   logic [COMP_BITS-1:0]  m_g [NUM_PIX];
   logic [COMP_BITS-1:0]  m_b [NUM_PIX];
   dc_word_u              m_dc [NUM_DC];
   logic [23:0]           m_bc;
   logic [6:0]            m_fc;
   logic [FRAME_BITS-1:0] exp_frame [NUM_GROUPS]; // Frame captured at the start
   logic                  exp_cfg;
   int                    phase;                 // 0 idle, 1..576 shifting, then tail
   logic                  armed;                 // One edge seen after reset
   logic                  sck_low_exp;           // gssck level expected while clk is low

   // Grayscale frame from driver 1 LED 7 down to driver 0 LED 0
   function automatic logic [FRAME_BITS-1:0] gs_frame_of(int g);
      logic [FRAME_BITS-1:0] f;
      int pos;
      int p;
      f   = '0;
      pos = FRAME_BITS - 1;
      for (int d = DRIVERS_PER_GROUP - 1; d >= 0; d--)
         for (int l = LEDS_PER_DRIVER - 1; l >= 0; l--)
         begin
            p = 16 * g + 8 * d + l;
            f[pos -: 36] = {4'h0, m_b[p], 4'h0, m_g[p], 4'h0, m_r[p]}; // B G R slots
            pos -= 36;
         end
      return f;
   endfunction

   // Configuration frame per driver with 89 zeros, FC and BC ahead of the DC words
   function automatic logic [FRAME_BITS-1:0] cfg_frame_of(int g);
      logic [FRAME_BITS-1:0] f;
      int pos;
      int w;
      f   = '0;
      pos = FRAME_BITS - 1;
      for (int d = DRIVERS_PER_GROUP - 1; d >= 0; d--)
      begin
         pos -= CFG_PAD_BITS;
         f[pos -: 31] = {m_fc, m_bc};
         pos -= 31;
         for (int l = LEDS_PER_DRIVER - 1; l >= 0; l--)
         begin
            w = 32 * g + 16 * d + 2 * l;
            f[pos -: 21] = {m_dc[w + 1].b.blue, m_dc[w].rg.green, m_dc[w].rg.red};
            pos -= 21;
         end
      end
      return f;
   endfunction

   task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("Fail %s at %0t: got %h expected %h", name, $time, got, exp);
      end
   endtask

   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         armed <= 1'b0;
      else
         armed <= 1'b1;
   end

   // Everything sampled mid-cycle, well away from the driving edge
   always @(negedge clk)
   begin
      logic [NUM_GROUPS-1:0] e_gssin;
      logic                  shifting;
      if (!rst_n)
      begin
         errors = 0;
         phase  = 0;
         m_bc   = '0;
         m_fc   = '0;
         for (int i = 0; i < NUM_PIX; i++)
         begin
            m_r[i] = '0;
            m_g[i] = '0;
            m_b[i] = '0;
         end
         for (int i = 0; i < NUM_DC; i++)
            m_dc[i] = '0;
      end
      else
      begin
         if (armed)
         begin
            shifting = (phase >= 1) && (phase <= FRAME_BITS);
            sck_low_exp = shifting;
            compare("ready", 32'(ready), 32'(!shifting));
            compare("gslat", 32'(gslat), 32'(shifting ? exp_cfg : (phase == FRAME_BITS + 2)));
            compare("xblink", 32'(xblink), 32'(phase != LAST_PHASE));
            compare("config_has_started", 32'(config_has_started),
                    32'((phase == 1) && exp_cfg));
            if (shifting)
            begin
               for (int g = 0; g < NUM_GROUPS; g++)
                  e_gssin[g] = exp_frame[g][FRAME_BITS - phase]; // Bit 575 first
               compare("gssin", 32'(gssin), 32'(e_gssin));
            end
            // Starts count only in idle and config wins a tie
            if (phase == 0)
            begin
               if (config_shift_start || pixel_shift_start)
               begin
                  exp_cfg = config_shift_start;
                  for (int g = 0; g < NUM_GROUPS; g++)
                     exp_frame[g] = exp_cfg ? cfg_frame_of(g) : gs_frame_of(g);
                  phase = 1;
               end
            end
            else if (phase == LAST_PHASE)
               phase = 0;
            else
               phase++;
         end
         // Stores land after the frame capture of this same cycle
         if (store_pixel)
         begin
            case (pixel_addr[1:0])
               2'd0: m_r[pixel_addr[8:2]] = pixel_data;
               2'd1: m_g[pixel_addr[8:2]] = pixel_data;
               2'd2: m_b[pixel_addr[8:2]] = pixel_data;
               default: ; // No colour at sub-address 3
            endcase
         end
         if (store_config)
         begin
            if (32'(config_addr) < NUM_DC)
               m_dc[config_addr] = config_data; // Frame reads only the fields of its view
            else if (32'(config_addr) == NUM_DC)
               m_bc[15:0] = config_data;
            else if (32'(config_addr) == NUM_DC + 1)
               m_bc[23:16] = config_data[7:0];
            else if (32'(config_addr) == NUM_DC + 2)
               m_fc = config_data[6:0];
         end
      end
   end

   // gssck is the inverted clock while shifting and low otherwise
   always @(negedge clk)
   begin
      #2;
      if (armed)
         compare("gssck", 32'(gssck), 32'(sck_low_exp));
   end

   always @(posedge clk)
   begin
      #2;
      if (armed)
         compare("gssck", 32'(gssck), 32'(0)); // Low in the high clock phase
   end

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   // Reset held over 3 rising edges, released away from any edge
   initial
   begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== verification/tb_led_shift_register.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_led_shift_register
   import led_pkg::*;
();

   localparam int NUM_GROUPS = 8;
   localparam int NUM_PIX    = NUM_GROUPS * 16;

   localparam int OP_STORE_PIX   = 0;
   localparam int OP_STORE_CFG   = 1;
   localparam int OP_START_PIX   = 2;
   localparam int OP_START_CFG   = 3;
   localparam int OP_START_BOTH  = 4; // Both strobes in one cycle
   localparam int OP_START_BUSY  = 5; // Both strobes while a frame runs

   logic                     clk;
   logic                     rst_n;
   logic [PIX_ADDR_BITS-1:0] pixel_addr;
   logic [COMP_BITS-1:0]     pixel_data;
   logic                     store_pixel;
   logic [CFG_WORD_BITS-1:0] config_data;
   logic [CFG_ADDR_BITS-1:0] config_addr;
   logic                     store_config;
   logic                     pixel_shift_start;
   logic                     config_shift_start;
   logic                     config_has_started;
   logic                     ready;
   logic                     gssck;
   logic                     gslat;
   logic                     xblink;
   logic [NUM_GROUPS-1:0]    gssin;
   int                       checker_errors;

   // Stimulus table of operation, address, data and the gslat level of the frame
   int          op_q [$];
   logic [8:0]  addr_q [$];
   logic [15:0] data_q [$];
   logic        exp_q [$];
   int          seed = 32'h922f_5dad;
   int          table_errors = 0;
   int          frames_started = 0;
   int          frames_done = 0;
   logic        xblink_prev = 1'b0;
   logic        table_built = 1'b0;

   tb_clock u_clock (.clk, .rst_n);

   led_shift_register #(.NUM_GROUPS(NUM_GROUPS)) u_dut (
      .clk, .rst_n, .pixel_addr, .pixel_data, .store_pixel, .config_data, .config_addr,
      .store_config, .pixel_shift_start, .config_shift_start, .config_has_started,
      .ready, .gssck, .gssin, .gslat, .xblink
   );

   tb_checker #(.NUM_GROUPS(NUM_GROUPS)) u_checker (
      .clk, .rst_n, .pixel_addr, .pixel_data, .store_pixel, .config_data, .config_addr,
      .store_config, .pixel_shift_start, .config_shift_start, .config_has_started,
      .ready, .gssck, .gssin, .gslat, .xblink, .errors(checker_errors)
   );

   bind led_shift_register led_shift_register_properties u_properties (
      .clk, .rst_n, .pixel_shift_start, .config_shift_start,
      .ready, .gslat, .xblink, .config_has_started
   );

   function automatic void add_row(int op, logic [8:0] addr, logic [15:0] data, logic exp);
      op_q.push_back(op);
      addr_q.push_back(addr);
      data_q.push_back(data);
      exp_q.push_back(exp);
   endfunction

   task automatic build_table();
      for (int p = 0; p < NUM_PIX; p++)
         for (int c = 0; c < 3; c++)
            add_row(OP_STORE_PIX, {7'(p), 2'(c)}, 16'($random(seed)), 1'b0);
      for (int p = 0; p < 4; p++)
         add_row(OP_STORE_PIX, {7'(p * 5), 2'd3}, 16'($random(seed)), 1'b0); // No effect
      add_row(OP_START_PIX, '0, '0, 1'b0);
      add_row(OP_START_BUSY, '0, '0, 1'b0);
      for (int p = 48; p < 64; p++)
         add_row(OP_STORE_PIX, {7'(p), 2'd0}, 16'($random(seed)), 1'b0); // For the last frame
      for (int p = 48; p < 52; p++)
         add_row(OP_STORE_PIX, {7'(p), 2'd3}, 16'($random(seed)), 1'b0);
      for (int a = 0; a < 2 * NUM_PIX; a++)
         add_row(OP_STORE_CFG, 9'(a), 16'($random(seed)), 1'b0);
      add_row(OP_STORE_CFG, 9'(2 * NUM_PIX), 16'h3c5a, 1'b0);     // BC low
      add_row(OP_STORE_CFG, 9'(2 * NUM_PIX + 1), 16'h00a7, 1'b0); // BC high
      add_row(OP_STORE_CFG, 9'(2 * NUM_PIX + 2), 16'h0055, 1'b0); // FC
      add_row(OP_START_CFG, '0, '0, 1'b1);
      add_row(OP_START_BUSY, '0, '0, 1'b0);
      add_row(OP_START_BOTH, '0, '0, 1'b1);
      add_row(OP_START_PIX, '0, '0, 1'b0);
      table_built = 1'b1;
   endtask

   // A frame is over once its blanking cycle has been seen
   always @(negedge clk)
   begin
      if (rst_n && xblink_prev && !xblink)
         frames_done++;
      xblink_prev <= xblink;
   end

   task automatic clear_strobes();
      @(posedge clk);
      store_pixel        <= 1'b0;
      store_config       <= 1'b0;
      pixel_shift_start  <= 1'b0;
      config_shift_start <= 1'b0;
   endtask

   task automatic apply_row(int i);
      int op;
      op = op_q[i];
      if (op == OP_START_PIX || op == OP_START_CFG || op == OP_START_BOTH)
      begin
         clear_strobes();
         wait (frames_done == frames_started); // DUT back in idle
      end
      @(posedge clk);
      store_pixel        <= (op == OP_STORE_PIX);
      store_config       <= (op == OP_STORE_CFG);
      pixel_addr         <= addr_q[i];
      pixel_data         <= data_q[i][7:0];
      config_addr        <= addr_q[i];
      config_data        <= data_q[i];
      pixel_shift_start  <= (op == OP_START_PIX || op == OP_START_BOTH || op == OP_START_BUSY);
      config_shift_start <= (op == OP_START_CFG || op == OP_START_BOTH || op == OP_START_BUSY);
      if (op == OP_START_PIX || op == OP_START_CFG || op == OP_START_BOTH)
      begin
         frames_started++;
         clear_strobes();
         wait (ready == 1'b0);
         @(negedge clk);
         if (gslat !== exp_q[i])
         begin
            table_errors++;
            $display("Fail gslat in row %0d: got %h expected %h", i, gslat, exp_q[i]);
         end
      end
   endtask

   // Watchdog scaled to the table length
   initial
   begin
      wait (table_built);
      #(op_q.size() * 600 * 10);
      $display("Timeout: the DUT did not finish the stimulus table in time");
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      pixel_addr         = '0;
      pixel_data         = '0;
      store_pixel        = 1'b0;
      config_data        = '0;
      config_addr        = '0;
      store_config       = 1'b0;
      pixel_shift_start  = 1'b0;
      config_shift_start = 1'b0;
      build_table();
      wait (rst_n);
      repeat (2) @(posedge clk);
      for (int i = 0; i < op_q.size(); i++)
         apply_row(i);
      clear_strobes();
      wait (frames_done == frames_started);
      repeat (4) @(posedge clk);
      $display("Error counts: checker %0d, stimulus table %0d", checker_errors, table_errors);
      if (checker_errors == 0 && table_errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire
